//--- flist.f
+incdir+.
tiler_pkg.sv
tiler_cfg_if.sv
tiler_cfg_regs.sv
tiler_dim_split.sv
tiler_seq_mult.sv
tiler_calc.sv
tiler_top.sv
tiler_sva.sv
tb_tiler_clkgen.sv
tb_tiler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the tiling calculator testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tiler -f flist.f -o tb_tiler_sim
./obj_dir/tb_tiler_sim

//--- tb_tiler.sv
// Testbench top that replays the pattern file through the req/ack handshake and checks all results
`timescale 1ns/1ps

module tb_tiler;

  localparam int NUM_TESTS       = 12;
  localparam int COLS            = 18;
  localparam int NUM_RESULTS     = 13;
  localparam int HOLD_CYCLES     = 3;
  localparam int CLK_PERIOD_NS   = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_TEST = 100;

  logic                clk_int;
  logic                rst_ni;
  logic                req_i;
  tiler_pkg::size_t    m_size_i;
  tiler_pkg::size_t    k_size_i;
  tiler_pkg::size_t    n_size_i;
  tiler_pkg::gemm_op_t gemm_op_i;
  tiler_pkg::fmt_t     in_fmt_i;
  logic                ack_o;
  tiler_pkg::iter_t    x_rows_iter_o, x_cols_iter_o, w_rows_iter_o, w_cols_iter_o;
  tiler_pkg::lftovr_t  x_rows_lftovr_o, x_cols_lftovr_o, w_rows_lftovr_o, w_cols_lftovr_o;
  tiler_pkg::lftovr_t  x_slots_o;
  tiler_pkg::iter_t    tot_stores_o;
  tiler_pkg::count_t   tot_x_read_o;
  tiler_pkg::count_t   w_tot_len_o;
  tiler_pkg::op_sel_t  op_sel_o;

  // Five input words then thirteen expected results per test
  logic [31:0] patterns [0:NUM_TESTS*COLS-1];

  tb_tiler_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
    .clk_o  (clk_int),
    .rst_no (rst_ni)
  );

  tiler_top uut (.*);

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("test failed");
      $fatal(1, "result mismatch");
    end
  endtask

  function automatic logic [31:0] result_word(input int k);
    case (k)
      0:       return 32'(x_rows_iter_o);
      1:       return 32'(x_cols_iter_o);
      2:       return 32'(w_rows_iter_o);
      3:       return 32'(w_cols_iter_o);
      4:       return 32'(x_rows_lftovr_o);
      5:       return 32'(x_cols_lftovr_o);
      6:       return 32'(w_rows_lftovr_o);
      7:       return 32'(w_cols_lftovr_o);
      8:       return 32'(x_slots_o);
      9:       return 32'(tot_stores_o);
      10:      return tot_x_read_o;
      11:      return w_tot_len_o;
      default: return op_sel_o;
    endcase
  endfunction

  function automatic string result_name(input int k);
    case (k)
      0:       return "x_rows_iter_o";
      1:       return "x_cols_iter_o";
      2:       return "w_rows_iter_o";
      3:       return "w_cols_iter_o";
      4:       return "x_rows_lftovr_o";
      5:       return "x_cols_lftovr_o";
      6:       return "w_rows_lftovr_o";
      7:       return "w_cols_lftovr_o";
      8:       return "x_slots_o";
      9:       return "tot_stores_o";
      10:      return "tot_x_read_o";
      11:      return "w_tot_len_o";
      default: return "op_sel_o";
    endcase
  endfunction

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_int);
    #1;
  endtask

  task automatic check_results(input int idx, input int base);
    for (int k = 0; k < NUM_RESULTS; k++) begin
      check_value($sformatf("pattern %0d %s", idx, result_name(k)),
                  patterns[base+5+k], result_word(k));
    end
  endtask

  task automatic run_pattern(input int idx);
    int base;
    base = idx * COLS;
    m_size_i  = patterns[base][15:0];
    k_size_i  = patterns[base+1][15:0];
    n_size_i  = patterns[base+2][15:0];
    gemm_op_i = patterns[base+3][2:0];
    in_fmt_i  = patterns[base+4][2:0];
    req_i     = 1'b1;
    next_cycle();
    // No result can be ready in the cycle the request is taken
    check_value($sformatf("pattern %0d ack_o right after req_i", idx), 32'd0, 32'(ack_o));
    while (ack_o !== 1'b1) next_cycle();
    // Ack and results must hold for as long as req stays up
    for (int h = 0; h < HOLD_CYCLES; h++) begin
      check_value($sformatf("pattern %0d ack_o held", idx), 32'd1, 32'(ack_o));
      check_results(idx, base);
      next_cycle();
    end
    req_i = 1'b0;
    next_cycle();
    while (ack_o !== 1'b0) next_cycle();
    check_results(idx, base);
  endtask

  initial begin
    #(CLK_PERIOD_NS * (RESET_CYCLES + 10 + NUM_TESTS * CYCLES_PER_TEST));
    $display("ERROR: the req/ack handshake never completed within the time limit");
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    req_i     = 1'b0;
    m_size_i  = '0;
    k_size_i  = '0;
    n_size_i  = '0;
    gemm_op_i = '0;
    in_fmt_i  = '0;
    $readmemh("tiler_patterns.txt", patterns);
    wait (rst_ni === 1'b1);
    next_cycle();
    check_value("reset ack_o", 32'd0, 32'(ack_o));
    for (int k = 0; k < NUM_RESULTS; k++) begin
      check_value($sformatf("reset %s", result_name(k)), 32'd0, result_word(k));
    end
    // Requests follow each other with no idle gap beyond the handshake
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_pattern(t);
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- tb_tiler_clkgen.sv
// Clock and reset source that tb_tiler instantiates for the tiling calculator testbench
`timescale 1ns/1ps

module tb_tiler_clkgen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Reset is released 1 ns after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- tiler_calc.sv
// Tile arithmetic, multiplier chain and FPU operation decode feeding the registered result
`timescale 1ns/1ps
`include "tiler_consts.svh"

module tiler_calc (
  input  logic               clk_int,
  input  logic               rst_ni,
  tiler_cfg_if.calc          cfg,
  output tiler_pkg::iter_t   x_rows_iter_o,
  output tiler_pkg::iter_t   x_cols_iter_o,
  output tiler_pkg::iter_t   w_rows_iter_o,
  output tiler_pkg::iter_t   w_cols_iter_o,
  output tiler_pkg::lftovr_t x_rows_lftovr_o,
  output tiler_pkg::lftovr_t x_cols_lftovr_o,
  output tiler_pkg::lftovr_t w_rows_lftovr_o,
  output tiler_pkg::lftovr_t w_cols_lftovr_o,
  output tiler_pkg::lftovr_t x_slots_o,
  output tiler_pkg::iter_t   tot_stores_o,
  output tiler_pkg::count_t  tot_x_read_o,
  output tiler_pkg::count_t  w_tot_len_o,
  output tiler_pkg::op_sel_t op_sel_o
);

  tiler_pkg::iter_t   x_rows_iter, x_cols_iter, w_cols_iter, w_rows_ceil;
  tiler_pkg::iter_t   w_rows_iter;
  tiler_pkg::lftovr_t x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr;
  tiler_pkg::lftovr_t x_slots;

  tiler_pkg::count_t prod_rw;
  logic [47:0]       prod_x;
  logic [47:0]       prod_w;
  logic              done_rw, done_x, done_w;
  logic              res_load;

  logic [2:0] st1_rnd, st2_rnd, fpu_fmt;
  logic [4:0] st1_op;
  logic       gemm_sel;

  tiler_dim_split #(.TILE_DIV(`TILER_ARRAY_WIDTH)) u_split_x_rows (
    .size_i(cfg.m_size), .full_o(), .lftovr_o(x_rows_lftovr), .iter_o(x_rows_iter)
  );
  tiler_dim_split #(.TILE_DIV(`TILER_TILE)) u_split_x_cols (
    .size_i(cfg.n_size), .full_o(), .lftovr_o(x_cols_lftovr), .iter_o(x_cols_iter)
  );
  tiler_dim_split #(.TILE_DIV(`TILER_TILE)) u_split_w_cols (
    .size_i(cfg.k_size), .full_o(), .lftovr_o(w_cols_lftovr), .iter_o(w_cols_iter)
  );
  tiler_dim_split #(.TILE_DIV(`TILER_ARRAY_HEIGHT)) u_split_w_rows (
    .size_i(cfg.n_size), .full_o(), .lftovr_o(w_rows_lftovr), .iter_o(w_rows_ceil)
  );

  // N and the X leftover padded up to whole array columns
  assign w_rows_iter = tiler_pkg::iter_t'(w_rows_ceil * `TILER_ARRAY_HEIGHT);
  assign x_slots = tiler_pkg::lftovr_t'((x_cols_lftovr + `TILER_ARRAY_HEIGHT - 1) /
                                        `TILER_ARRAY_HEIGHT * `TILER_ARRAY_HEIGHT);

  // x_rows * w_cols first, then both wide products off its done pulse
  tiler_seq_mult #(.A_W(16), .B_W(16)) u_mult_rw (
    .clk_int(clk_int), .rst_ni(rst_ni), .start_i(cfg.start),
    .a_i(x_rows_iter), .b_i(w_cols_iter), .done_o(done_rw), .prod_o(prod_rw)
  );
  tiler_seq_mult #(.A_W(16), .B_W(32)) u_mult_x (
    .clk_int(clk_int), .rst_ni(rst_ni), .start_i(done_rw),
    .a_i(x_cols_iter), .b_i(prod_rw), .done_o(done_x), .prod_o(prod_x)
  );
  tiler_seq_mult #(.A_W(16), .B_W(32)) u_mult_w (
    .clk_int(clk_int), .rst_ni(rst_ni), .start_i(done_rw),
    .a_i(w_rows_iter), .b_i(prod_rw), .done_o(done_w), .prod_o(prod_w)
  );

  assign res_load = done_x && done_w;
  assign cfg.done = res_load;

  always_comb begin
    st1_op  = `TILER_FPU_MINMAX;
    st1_rnd = `TILER_RND_RNE;
    st2_rnd = `TILER_RND_RTZ;
    case (cfg.gemm_op)
      `TILER_GEMM_MATMUL, `TILER_GEMM_GEMM: begin
        st1_op  = `TILER_FPU_FMADD;
        st2_rnd = `TILER_RND_RNE;
      end
      `TILER_GEMM_ADDMAX: st1_op = `TILER_FPU_ADD;
      `TILER_GEMM_ADDMIN: begin
        st1_op  = `TILER_FPU_ADD;
        st2_rnd = `TILER_RND_RNE;
      end
      `TILER_GEMM_MULMAX: st1_op = `TILER_FPU_MUL;
      `TILER_GEMM_MULMIN: begin
        st1_op  = `TILER_FPU_MUL;
        st2_rnd = `TILER_RND_RNE;
      end
      `TILER_GEMM_MAXMIN: begin
        st1_rnd = `TILER_RND_RTZ;
        st2_rnd = `TILER_RND_RNE;
      end
      default: st1_op = `TILER_FPU_MINMAX;
    endcase
  end

  always_comb begin
    case (cfg.in_fmt)
      `TILER_FMT_FLOAT16:    fpu_fmt = `TILER_FPU_FP16;
      `TILER_FMT_FLOAT8:     fpu_fmt = `TILER_FPU_FP8;
      `TILER_FMT_FLOAT16ALT: fpu_fmt = `TILER_FPU_FP16ALT;
      default:               fpu_fmt = `TILER_FPU_FP8ALT;
    endcase
  end

  assign gemm_sel = (cfg.gemm_op != `TILER_GEMM_MATMUL);

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      x_rows_iter_o   <= '0;
      x_cols_iter_o   <= '0;
      w_rows_iter_o   <= '0;
      w_cols_iter_o   <= '0;
      x_rows_lftovr_o <= '0;
      x_cols_lftovr_o <= '0;
      w_rows_lftovr_o <= '0;
      w_cols_lftovr_o <= '0;
      x_slots_o       <= '0;
      tot_stores_o    <= '0;
      tot_x_read_o    <= '0;
      w_tot_len_o     <= '0;
      op_sel_o        <= '0;
    end else if (res_load) begin
      x_rows_iter_o   <= x_rows_iter;
      x_cols_iter_o   <= x_cols_iter;
      w_rows_iter_o   <= w_rows_iter;
      w_cols_iter_o   <= w_cols_iter;
      x_rows_lftovr_o <= x_rows_lftovr;
      x_cols_lftovr_o <= x_cols_lftovr;
      w_rows_lftovr_o <= w_rows_lftovr;
      w_cols_lftovr_o <= w_cols_lftovr;
      x_slots_o       <= x_slots;
      tot_stores_o    <= prod_rw[15:0];
      tot_x_read_o    <= prod_x[31:0];
      w_tot_len_o     <= prod_w[31:0];
      // Computing format follows the input format
      op_sel_o        <= {st1_rnd, st2_rnd, st1_op, `TILER_FPU_MINMAX,
                          fpu_fmt, fpu_fmt, 9'd0, gemm_sel};
    end
  end

endmodule

//--- tiler_cfg_if.sv
// Latched configuration and start/done pair between the register block and the calculator
`timescale 1ns/1ps

interface tiler_cfg_if;

  tiler_pkg::size_t    m_size;
  tiler_pkg::size_t    k_size;
  tiler_pkg::size_t    n_size;
  tiler_pkg::gemm_op_t gemm_op;
  tiler_pkg::fmt_t     in_fmt;

  // One-cycle pulses
  logic start;
  logic done;

  modport regs (
    output m_size, k_size, n_size, gemm_op, in_fmt, start,
    input  done
  );

  modport calc (
    input  m_size, k_size, n_size, gemm_op, in_fmt, start,
    output done
  );

endinterface

//--- tiler_cfg_regs.sv
// Four-phase req/ack controller that latches the host configuration and starts the calculator
`timescale 1ns/1ps

module tiler_cfg_regs (
  input  logic                clk_int,
  input  logic                rst_ni,
  input  logic                req_i,
  input  tiler_pkg::size_t    m_size_i,
  input  tiler_pkg::size_t    k_size_i,
  input  tiler_pkg::size_t    n_size_i,
  input  tiler_pkg::gemm_op_t gemm_op_i,
  input  tiler_pkg::fmt_t     in_fmt_i,
  output logic                ack_o,
  tiler_cfg_if.regs           cfg
);

  tiler_pkg::hs_state_e state_q;
  logic                 start_q;
  logic                 cfg_load;

  tiler_pkg::size_t    m_size_q;
  tiler_pkg::size_t    k_size_q;
  tiler_pkg::size_t    n_size_q;
  tiler_pkg::gemm_op_t gemm_op_q;
  tiler_pkg::fmt_t     in_fmt_q;

  // A new request is only taken while idle
  assign cfg_load = (state_q == tiler_pkg::IDLE) && req_i;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tiler_pkg::IDLE;
      start_q <= 1'b0;
      ack_o   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        tiler_pkg::IDLE: begin
          if (req_i) begin
            state_q <= tiler_pkg::BUSY;
            start_q <= 1'b1;
          end
        end
        tiler_pkg::BUSY: begin
          if (cfg.done) begin
            state_q <= tiler_pkg::ACK;
            ack_o   <= 1'b1;
          end
        end
        tiler_pkg::ACK: begin
          // Hold ack until the host withdraws its request
          if (!req_i) begin
            state_q <= tiler_pkg::IDLE;
            ack_o   <= 1'b0;
          end
        end
        default: state_q <= tiler_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_int) begin
    if (cfg_load) begin
      m_size_q  <= m_size_i;
      k_size_q  <= k_size_i;
      n_size_q  <= n_size_i;
      gemm_op_q <= gemm_op_i;
      in_fmt_q  <= in_fmt_i;
    end
  end

  assign cfg.m_size  = m_size_q;
  assign cfg.k_size  = k_size_q;
  assign cfg.n_size  = n_size_q;
  assign cfg.gemm_op = gemm_op_q;
  assign cfg.in_fmt  = in_fmt_q;
  assign cfg.start   = start_q;

endmodule

//--- tiler_consts.svh
// Array geometry, widths and operation/format codes included by RTL and testbench sources
`ifndef TILER_CONSTS_SVH
`define TILER_CONSTS_SVH

// Processing array geometry
`define TILER_ARRAY_WIDTH  12
`define TILER_ARRAY_HEIGHT 4
`define TILER_PIPE_REGS    3
`define TILER_TILE         ((`TILER_ARRAY_HEIGHT) * ((`TILER_PIPE_REGS) + 1))

// Datapath widths
`define TILER_SIZE_W  16
`define TILER_COUNT_W 32

// FPU stage operations
`define TILER_FPU_FMADD  5'd0
`define TILER_FPU_ADD    5'd2
`define TILER_FPU_MUL    5'd3
`define TILER_FPU_MINMAX 5'd7

// Rounding modes
`define TILER_RND_RNE 3'd0
`define TILER_RND_RTZ 3'd1

// FPU formats
`define TILER_FPU_FP16    3'd2
`define TILER_FPU_FP8     3'd3
`define TILER_FPU_FP16ALT 3'd4
`define TILER_FPU_FP8ALT  3'd5

// GEMM operation codes from the host
`define TILER_GEMM_MATMUL 3'd0
`define TILER_GEMM_GEMM   3'd1
`define TILER_GEMM_ADDMAX 3'd2
`define TILER_GEMM_ADDMIN 3'd3
`define TILER_GEMM_MULMAX 3'd4
`define TILER_GEMM_MULMIN 3'd5
`define TILER_GEMM_MAXMIN 3'd6

// Input formats from the host
`define TILER_FMT_FLOAT16    3'd0
`define TILER_FMT_FLOAT8     3'd1
`define TILER_FMT_FLOAT16ALT 3'd2

`endif

//--- tiler_dim_split.sv
// Splits one matrix dimension into full tiles, leftover and rounded-up tile count
`timescale 1ns/1ps

module tiler_dim_split #(
  parameter int unsigned TILE_DIV = 16
) (
  input  tiler_pkg::size_t   size_i,
  output tiler_pkg::iter_t   full_o,
  output tiler_pkg::lftovr_t lftovr_o,
  output tiler_pkg::iter_t   iter_o
);

  localparam tiler_pkg::size_t DIV = tiler_pkg::size_t'(TILE_DIV);

  tiler_pkg::size_t quot;
  tiler_pkg::size_t rem;

  assign quot = size_i / DIV;
  assign rem  = size_i % DIV;

  assign full_o   = tiler_pkg::iter_t'(quot);
  assign lftovr_o = tiler_pkg::lftovr_t'(rem);

  // A partial tile still costs one more iteration
  always_comb begin
    if (rem != '0) begin
      iter_o = full_o + tiler_pkg::iter_t'(1);
    end else begin
      iter_o = full_o;
    end
  end

endmodule

//--- tiler_patterns.txt
// m k n gemm_op in_fmt, then x_rows_iter x_cols_iter w_rows_iter w_cols_iter x_rows_lftovr
// x_cols_lftovr w_rows_lftovr w_cols_lftovr x_slots tot_stores tot_x_read w_tot_len op_sel (hex)
18 20 40 0 0 2 4 40 2 0 0 0 0 0 4 10 100 00074800
19 21 41 1 1 3 5 44 3 1 1 1 1 4 9 2D 264 00076C01
64 32 1E 2 2 9 2 20 4 4 E 2 2 10 24 48 480 04479001
7 5 3 3 3 1 1 4 1 7 3 3 5 4 1 1 4 0047B401
30 30 30 4 0 4 3 30 3 0 0 0 0 0 C 24 240 04674801
D 11 12 5 1 2 2 14 2 1 2 2 1 4 4 8 50 00676C01
24 10 4 6 2 3 1 4 1 0 4 0 0 4 3 3 C 20E79001
1 1 1 7 7 1 1 4 1 1 1 1 1 4 1 1 4 04E7B401
FFFF FFFF FFFC 0 0 1556 1000 FFFC 1000 3 C 0 F C 6000 56000000 5AAA8000 00074800
EA60 9C40 C350 1 2 1388 C35 C350 9C4 0 0 0 0 0 BC20 184E72A0 84E72A00 00079001
0 0 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 04476C01
B F F 5 4 1 1 10 1 B F 3 F 10 1 1 10 0067B401

//--- tiler_pkg.sv
// Shared types of the tiling calculator referenced by scoped name from RTL and testbench
`include "tiler_consts.svh"

package tiler_pkg;

  // Matrix dimension as given by the host
  typedef logic [`TILER_SIZE_W-1:0] size_t;

  // Tile iteration count along one dimension
  typedef logic [`TILER_SIZE_W-1:0] iter_t;

  // Elements left over after the last full tile
  typedef logic [7:0] lftovr_t;

  // Total store, read and length counts
  typedef logic [`TILER_COUNT_W-1:0] count_t;

  // Host-side operation and format codes
  typedef logic [2:0] gemm_op_t;
  typedef logic [2:0] fmt_t;

  // Packed FPU operation selection word
  typedef logic [31:0] op_sel_t;

  // Four-phase handshake controller states
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    ACK
  } hs_state_e;

endpackage

//--- tiler_seq_mult.sv
// Shift-add sequential multiplier that handles one multiplier bit per cycle after a start pulse
`timescale 1ns/1ps

module tiler_seq_mult #(
  parameter int unsigned A_W = 16,
  parameter int unsigned B_W = 16
) (
  input  logic                 clk_int,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic [A_W-1:0]       a_i,
  input  logic [B_W-1:0]       b_i,
  output logic                 done_o,
  output logic [A_W+B_W-1:0]   prod_o
);

  localparam int unsigned P_W   = A_W + B_W;
  localparam int unsigned CNT_W = $clog2(A_W);

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [A_W-1:0]   a_q;
  logic [P_W-1:0]   b_q;
  logic [P_W-1:0]   acc_q;
  logic             load;

  // Starts arriving mid-run are dropped
  assign load = start_i && !busy_q;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(A_W - 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - CNT_W'(1);
        if (cnt_q == CNT_W'(1)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // Bit 0 of the multiplier is consumed while loading
  always_ff @(posedge clk_int) begin
    if (load) begin
      a_q   <= a_i >> 1;
      b_q   <= P_W'(b_i) << 1;
      acc_q <= a_i[0] ? P_W'(b_i) : '0;
    end else if (busy_q) begin
      if (a_q[0]) begin
        acc_q <= acc_q + b_q;
      end
      a_q <= a_q >> 1;
      b_q <= b_q << 1;
    end
  end

  assign prod_o = acc_q;

endmodule

//--- tiler_sva.sv
// Handshake and output-stability assertions bound into the tiling calculator top level
`timescale 1ns/1ps

module tiler_sva (
  input logic                clk_int,
  input logic                rst_ni,
  input logic                req_i,
  input logic                ack_o,
  input tiler_pkg::iter_t    x_rows_iter_o,
  input tiler_pkg::iter_t    x_cols_iter_o,
  input tiler_pkg::iter_t    w_rows_iter_o,
  input tiler_pkg::iter_t    w_cols_iter_o,
  input tiler_pkg::lftovr_t  x_rows_lftovr_o,
  input tiler_pkg::lftovr_t  x_cols_lftovr_o,
  input tiler_pkg::lftovr_t  w_rows_lftovr_o,
  input tiler_pkg::lftovr_t  w_cols_lftovr_o,
  input tiler_pkg::lftovr_t  x_slots_o,
  input tiler_pkg::iter_t    tot_stores_o,
  input tiler_pkg::count_t   tot_x_read_o,
  input tiler_pkg::count_t   w_tot_len_o,
  input tiler_pkg::op_sel_t  op_sel_o
);

  logic [215:0] results;

  assign results = {x_rows_iter_o, x_cols_iter_o, w_rows_iter_o, w_cols_iter_o,
                    x_rows_lftovr_o, x_cols_lftovr_o, w_rows_lftovr_o, w_cols_lftovr_o,
                    x_slots_o, tot_stores_o, tot_x_read_o, w_tot_len_o, op_sel_o};

  // One cycle of grace after the host withdraws req
  ack_drops_after_req: assert property (@(posedge clk_int) disable iff (!rst_ni)
    (!req_i && $past(!req_i)) |-> !ack_o)
    else $error("ack_o still high two cycles after req_i went low");

  ack_rises_with_req: assert property (@(posedge clk_int) disable iff (!rst_ni)
    $rose(ack_o) |-> req_i)
    else $error("ack_o rose without req_i");

  results_hold_under_ack: assert property (@(posedge clk_int) disable iff (!rst_ni)
    (ack_o && $past(ack_o)) |-> $stable(results))
    else $error("result outputs changed while ack_o was high");

endmodule

bind tiler_top tiler_sva u_sva (.*);

//--- tiler_top.sv
// Top level of the tiling calculator with plain ports for the host and the four-phase handshake
`timescale 1ns/1ps

module tiler_top (
  input  logic                clk_int,
  input  logic                rst_ni,
  input  logic                req_i,
  input  tiler_pkg::size_t    m_size_i,
  input  tiler_pkg::size_t    k_size_i,
  input  tiler_pkg::size_t    n_size_i,
  input  tiler_pkg::gemm_op_t gemm_op_i,
  input  tiler_pkg::fmt_t     in_fmt_i,
  output logic                ack_o,
  output tiler_pkg::iter_t    x_rows_iter_o,
  output tiler_pkg::iter_t    x_cols_iter_o,
  output tiler_pkg::iter_t    w_rows_iter_o,
  output tiler_pkg::iter_t    w_cols_iter_o,
  output tiler_pkg::lftovr_t  x_rows_lftovr_o,
  output tiler_pkg::lftovr_t  x_cols_lftovr_o,
  output tiler_pkg::lftovr_t  w_rows_lftovr_o,
  output tiler_pkg::lftovr_t  w_cols_lftovr_o,
  output tiler_pkg::lftovr_t  x_slots_o,
  output tiler_pkg::iter_t    tot_stores_o,
  output tiler_pkg::count_t   tot_x_read_o,
  output tiler_pkg::count_t   w_tot_len_o,
  output tiler_pkg::op_sel_t  op_sel_o
);

  tiler_cfg_if cfg_if ();

  tiler_cfg_regs u_cfg_regs (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .m_size_i  (m_size_i),
    .k_size_i  (k_size_i),
    .n_size_i  (n_size_i),
    .gemm_op_i (gemm_op_i),
    .in_fmt_i  (in_fmt_i),
    .ack_o     (ack_o),
    .cfg       (cfg_if)
  );

  tiler_calc u_calc (
    .clk_int         (clk_int),
    .rst_ni          (rst_ni),
    .cfg             (cfg_if),
    .x_rows_iter_o   (x_rows_iter_o),
    .x_cols_iter_o   (x_cols_iter_o),
    .w_rows_iter_o   (w_rows_iter_o),
    .w_cols_iter_o   (w_cols_iter_o),
    .x_rows_lftovr_o (x_rows_lftovr_o),
    .x_cols_lftovr_o (x_cols_lftovr_o),
    .w_rows_lftovr_o (w_rows_lftovr_o),
    .w_cols_lftovr_o (w_cols_lftovr_o),
    .x_slots_o       (x_slots_o),
    .tot_stores_o    (tot_stores_o),
    .tot_x_read_o    (tot_x_read_o),
    .w_tot_len_o     (w_tot_len_o),
    .op_sel_o        (op_sel_o)
  );

endmodule
